// File: bench/lsu_vectors.txt
# name op mode sew vl base stride vs2 vs3 err expect (op 0 load 1 store, mode 0 stride 1 index, sew 0 e8 1 e16 2 e32 3 e64)
# vl is decimal, the rest hex; expect is vd for a load, the element read-back for a store
ld_stride_e8 0 0 0 16 00000000 00000001 00000000000000000000000000000000 00000000000000000000000000000000 0 aaaba8a9aeafacada2a3a0a1a6a7a4a5
ld_stride_e32 0 0 2 3 00000010 0000000c 00000000000000000000000000000000 00000000000000000000000000000000 0 000000008e8f8c8dbabbb8b9b6b7b4b5
ld_neg_stride_e32 0 0 2 3 00000038 fffffff8 00000000000000000000000000000000 00000000000000000000000000000000 0 000000008e8f8c8d969794959e9f9c9d
ld_index_e16 0 1 1 8 00000040 00000000 000c0030001a0000000600200002000e 00000000000000000000000000000000 0 e8e9d4d5feffe4e5e2e3c4c5e6e7eaeb
st_stride_e16 1 0 1 4 00000080 00000004 00000000000000000000000000000000 00000000000000004444333322221111 0 00000000000000004444333322221111
ld_after_st_stride 0 0 0 16 00000080 00000001 00000000000000000000000000000000 00000000000000000000000000000000 0 2a2b44442e2f33332223222226271111
st_index_e8 1 1 0 4 000000c0 00000000 0000000000000000000000000e000903 000000000000000000000000817e3c5a 0 000000000000000000000000817e3c5a
ld_after_st_index 0 0 0 16 000000c0 00000001 00000000000000000000000000000000 00000000000000000000000000000000 0 6a8168696e6f3c6d626360615a67647e
bad_sew_e64 0 0 3 2 00000000 00000004 00000000000000000000000000000000 00000000000000000000000000000000 1 00000000000000000000000000000000
bad_vl_e32 0 0 2 5 00000000 00000004 00000000000000000000000000000000 00000000000000000000000000000000 1 00000000000000000000000000000000
bad_vl_st_e16 1 0 1 9 00000080 00000002 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 1 00000000000000000000000000000000
ld_after_bad_e32 0 0 2 4 00000080 00000004 00000000000000000000000000000000 00000000000000000000000000000000 0 2a2b44442e2f33332223222226271111
zero_vl 0 0 0 0 00000000 00000001 00000000000000000000000000000000 00000000000000000000000000000000 0 00000000000000000000000000000000

// File: all.f
hdl/lsu_pkg.sv
hdl/lsu_seq.sv
hdl/lsu_elem_gen.sv
hdl/lsu_mem_port.sv
hdl/lsu_writeback.sv
hdl/vec_lsu.sv
bench/mem_model.sv
bench/tb_vec_lsu.sv

// File: Bender.yml
package:
  name: vec_lsu

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_seq.sv
      - hdl/lsu_elem_gen.sv
      - hdl/lsu_mem_port.sv
      - hdl/lsu_writeback.sv
      - hdl/vec_lsu.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/tb_vec_lsu.sv

// File: bench/tb_vec_lsu.sv
// ********************
// Testbench for the vector load/store unit
// Reads one test per line from the vector file, drives it over the command port
// and checks cmd_err, memory traffic count, vd and the bytes a store left behind
// ********************
`timescale 1ns/1ps

module tb_vec_lsu;
    import lsu_pkg::*;

    localparam int half_period     = 4;      // 8 ns clock
    localparam int cycles_per_test = 200;    // Watchdog budget per vector line
    localparam     vector_file     = "bench/lsu_vectors.txt";

    // One parsed line of the vector file
    typedef struct packed {
        lsu_cmd_t        cmd;
        logic            err;      // Expected cmd_err
        logic [vlen-1:0] exp_vec;  // vd for loads, read-back elements for stores
    } test_vec_t;

    logic            clk;
    logic            n_rst;
    logic            cmd_req;
    lsu_cmd_t        cmd;
    logic            cmd_ack;
    logic            cmd_err;
    logic [vlen-1:0] vd_data;
    logic            mem_req;
    mem_req_t        mem;
    logic            mem_ack;
    logic [31:0]     mem_rdata;

    test_vec_t   tests[$];
    string       names[$];
    int          num_tests;
    int unsigned access_cnt;   // Completed memory handshakes

    vec_lsu #(.vlen(vlen)) vec_lsu_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .cmd_err   (cmd_err),
        .vd_data   (vd_data),
        .mem_req   (mem_req),
        .mem       (mem),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    mem_model #(.seed(32'hd165)) mem_model_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .mem_req   (mem_req),
        .mem       (mem),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // One count per handshake since the DUT drops mem_req on the edge it sees ack
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            access_cnt <= 0;
        end else if (mem_req && mem_ack) begin
            access_cnt <= access_cnt + 1;
        end
    end

    function automatic int elem_bytes(input sew_e s);
        case (s)
            e8:      return 1;
            e16:     return 2;
            default: return 4;
        endcase
    endfunction

    // Element i sits at base + i*stride, or at base + vs2[i] read at the element width
    function automatic logic [xlen-1:0] elem_address(input lsu_cmd_t c, input int i);
        int          w;
        logic [31:0] off;
        w   = elem_bytes(c.sew);
        off = '0;
        if (c.mode == mode_index) begin
            for (int b = 0; b < w; b++) begin
                off[8*b +: 8] = c.vs2[(i*w + b)*8 +: 8];
            end
            return c.base + off;
        end
        return c.base + i * c.stride;
    endfunction

    // Gather what a store left in memory with element i in slot i
    function automatic logic [vlen-1:0] read_back(input lsu_cmd_t c);
        logic [vlen-1:0] v;
        logic [xlen-1:0] a;
        logic [7:0]      ba;
        int              w;
        v = '0;
        w = elem_bytes(c.sew);
        for (int i = 0; i < int'(c.vl); i++) begin
            a = elem_address(c, i);
            for (int b = 0; b < w; b++) begin
                ba = 8'(a + xlen'(b));   // Model wraps at 256 bytes
                v[(i*w + b)*8 +: 8] = mem_model_inst.mem_bytes[ba];
            end
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [vlen-1:0] exp_val,
                               input logic [vlen-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Error: %s expected %h actual %h", what, exp_val, act_val);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              n;
        string           line;
        string           f_name;
        logic [31:0]     f_op;
        logic [31:0]     f_mode;
        logic [31:0]     f_sew;
        logic [31:0]     f_vl;
        logic [31:0]     f_base;
        logic [31:0]     f_stride;
        logic [31:0]     f_err;
        logic [vlen-1:0] f_vs2;
        logic [vlen-1:0] f_vs3;
        logic [vlen-1:0] f_exp;
        test_vec_t       tv;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", vector_file);
            $display("Regression failed");
            $fatal(1, "missing vector file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;   // Blank or comment
            end
            n = $sscanf(line, "%s %h %h %h %d %h %h %h %h %h %h", f_name, f_op, f_mode,
                        f_sew, f_vl, f_base, f_stride, f_vs2, f_vs3, f_err, f_exp);
            if (n != 11) begin
                $display("Malformed line in the vector file: %s", line);
                $display("Regression failed");
                $fatal(1, "bad vector line");
            end
            tv.cmd.op     = lsu_op_e'(f_op[0]);
            tv.cmd.mode   = lsu_mode_e'(f_mode[0]);
            tv.cmd.sew    = sew_e'(f_sew[1:0]);
            tv.cmd.vl     = f_vl[vl_w-1:0];
            tv.cmd.base   = f_base;
            tv.cmd.stride = f_stride;
            tv.cmd.vs2    = f_vs2;
            tv.cmd.vs3    = f_vs3;
            tv.err        = f_err[0];
            tv.exp_vec    = f_exp;
            tests.push_back(tv);
            names.push_back(f_name);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("The vector file holds no tests");
            $display("Regression failed");
            $fatal(1, "empty vector file");
        end
        num_tests = tests.size();
    endtask

    // Full four-phase command with the checks taken while cmd_ack is high
    task automatic run_test(input string name, input test_vec_t tv);
        int unsigned     start_cnt;
        logic [vlen-1:0] exp_cnt;
        start_cnt = access_cnt;
        cmd       = tv.cmd;
        cmd_req   = 1'b1;
        @(posedge clk);
        while (!cmd_ack) @(posedge clk);
        #1;
        check_value({name, " cmd_err"}, vlen'(tv.err), vlen'(cmd_err));
        exp_cnt = tv.err ? '0 : vlen'(tv.cmd.vl);   // One access per element
        check_value({name, " accesses"}, exp_cnt, vlen'(access_cnt - start_cnt));
        if (!tv.err && tv.cmd.op == op_load) begin
            check_value({name, " vd"}, tv.exp_vec, vd_data);
        end else if (!tv.err) begin
            check_value({name, " memory"}, tv.exp_vec, read_back(tv.cmd));
        end
        cmd_req = 1'b0;
        @(posedge clk);
        while (cmd_ack) @(posedge clk);
        #1;
    endtask

    initial begin : main
        n_rst    = 1'b0;
        cmd_req  = 1'b0;
        cmd      = '0;
        load_vectors();
        repeat (3) @(posedge clk);
        #1 n_rst = 1'b1;
        foreach (tests[k]) begin
            run_test(names[k], tests[k]);
        end
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    initial begin : watchdog
        wait (num_tests > 0);
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("Timeout: a command was never acknowledged in %0d cycles per test",
                 cycles_per_test);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: bench/mem_model.sv
// ********************
// Byte-addressed data memory for the LSU testbench, 256 bytes wrapping
// Answers the four-phase req/ack port after a random 0 to 4 cycle delay
// ********************
`timescale 1ns/1ps

module mem_model #(
    parameter int unsigned seed = 32'h1
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              mem_req,
    input  lsu_pkg::mem_req_t mem,
    output logic              mem_ack,
    output logic [31:0]       mem_rdata
);

    logic [7:0] mem_bytes [0:255];

    initial begin : responder
        int unsigned delay;
        logic [7:0]  word_base;   // Byte address of lane 0
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int a = 0; a < 256; a++) begin
            mem_bytes[a] = 8'(a) ^ 8'ha5;   // Preload pattern
        end
        void'($urandom(seed));
        wait (n_rst);
        forever begin
            @(posedge clk);
            if (mem_req) begin
                delay = $urandom % 5;
                repeat (delay) @(posedge clk);
                #1;
                word_base = {mem.addr[7:2], 2'b00};
                for (int b = 0; b < 4; b++) begin
                    if (mem.write && mem.strb[b]) begin
                        mem_bytes[word_base + b] = mem.wdata[8*b +: 8];
                    end
                    mem_rdata[8*b +: 8] = mem_bytes[word_base + b];   // Byte a in lane a mod 4
                end
                mem_ack = 1'b1;
                @(posedge clk);
                while (mem_req) @(posedge clk);   // Wait for the request to drop
                #1;
                mem_ack = 1'b0;
            end
        end
    end

endmodule

// File: hdl/vec_lsu.sv
// ********************
// Vector load/store unit top level
// Command port and memory port are both four-phase req/ack
// Four stages linked by valid/ready: seq, elem_gen, mem_port, writeback
// ********************
`timescale 1ns/1ps

module vec_lsu #(
    parameter int vlen = lsu_pkg::vlen
) (
    input  logic              clk,
    input  logic              n_rst,
    // Vector controller side
    input  logic              cmd_req,
    input  lsu_pkg::lsu_cmd_t cmd,
    output logic              cmd_ack,
    output logic              cmd_err,
    output logic [vlen-1:0]   vd_data,
    // Data memory side
    output logic              mem_req,
    output lsu_pkg::mem_req_t mem,
    input  logic              mem_ack,
    input  logic [31:0]       mem_rdata
);
    import lsu_pkg::*;

    lsu_cmd_t         cmd_q;        // Latched command, shared by the stages
    logic             new_cmd;
    logic             issue_valid;
    logic [idx_w-1:0] issue_idx;
    logic             issue_ready;
    logic             ereq_valid;
    elem_req_t        ereq;
    logic             ereq_ready;
    logic             rsp_valid;
    elem_rsp_t        rsp;
    logic             elem_done;

    lsu_seq #(.vlen(vlen)) seq_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .cmd_ack     (cmd_ack),
        .cmd_err     (cmd_err),
        .cmd_q       (cmd_q),
        .new_cmd     (new_cmd),
        .issue_valid (issue_valid),
        .issue_idx   (issue_idx),
        .issue_ready (issue_ready),
        .elem_done   (elem_done)
    );

    lsu_elem_gen #(.vlen(vlen)) elem_gen_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .cmd_q       (cmd_q),
        .issue_valid (issue_valid),
        .issue_idx   (issue_idx),
        .issue_ready (issue_ready),
        .ereq_valid  (ereq_valid),
        .ereq        (ereq),
        .ereq_ready  (ereq_ready)
    );

    lsu_mem_port mem_port_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .ereq_valid (ereq_valid),
        .ereq       (ereq),
        .ereq_ready (ereq_ready),
        .mem_req    (mem_req),
        .mem        (mem),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    lsu_writeback #(.vlen(vlen)) writeback_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .new_cmd   (new_cmd),
        .elem_done (elem_done),
        .vd_data   (vd_data)
    );

endmodule

// File: hdl/lsu_writeback.sv
// ********************
// Writeback stage of the LSU
// Places loaded elements into vd and reports each completion to the sequencer
// ********************
`timescale 1ns/1ps

module lsu_writeback #(
    parameter int vlen = lsu_pkg::vlen
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               rsp_valid,
    input  lsu_pkg::elem_rsp_t rsp,
    input  logic               new_cmd,    // Clears vd for the next command
    output logic               elem_done,
    output logic [vlen-1:0]    vd_data
);
    import lsu_pkg::*;

    logic [31:0] rsp_elem;   // Loaded element brought down to lane 0

    assign rsp_elem = rsp.rdata >> (8 * rsp.lane);

    // Loads and stores both count toward completion
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            elem_done <= 1'b0;
        end else begin
            elem_done <= rsp_valid;
        end
    end

    // Slots above vl keep the zeros from the clear
    always_ff @(posedge clk) begin
        if (new_cmd) begin
            vd_data <= '0;
        end else if (rsp_valid && !rsp.write) begin
            case (rsp.sew)
                e8:      vd_data[rsp.idx*8 +: 8]   <= rsp_elem[7:0];
                e16:     vd_data[rsp.idx*16 +: 16] <= rsp_elem[15:0];
                default: vd_data[rsp.idx*32 +: 32] <= rsp_elem;
            endcase
        end
    end

endmodule

// File: hdl/lsu_mem_port.sv
// ********************
// Memory stage of the LSU
// Runs one four-phase req/ack transaction per element
// and hands a response to writeback the cycle after mem_ack
// ********************
`timescale 1ns/1ps

module lsu_mem_port (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               ereq_valid,
    input  lsu_pkg::elem_req_t ereq,
    output logic               ereq_ready,
    output logic               mem_req,
    output lsu_pkg::mem_req_t  mem,
    input  logic               mem_ack,
    input  logic [31:0]        mem_rdata,
    output logic               rsp_valid,
    output lsu_pkg::elem_rsp_t rsp
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,       // Free for the next element
        st_wait_ack,   // mem_req high
        st_wait_drop   // mem_req low, memory still acking
    } port_state_e;

    port_state_e state;
    elem_req_t   cur;    // Element in flight on the memory port

    assign ereq_ready = (state == st_idle);

    // Request bundle stays stable for the whole handshake
    assign mem.write = cur.write;
    assign mem.addr  = cur.addr;
    assign mem.wdata = cur.wdata;
    assign mem.strb  = cur.strb;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state     <= st_idle;
            mem_req   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;   // Single-cycle response
            case (state)
                st_idle: begin
                    if (ereq_valid) begin
                        state   <= st_wait_ack;
                        mem_req <= 1'b1;
                    end
                end
                st_wait_ack: begin
                    if (mem_ack) begin
                        state     <= st_wait_drop;
                        mem_req   <= 1'b0;
                        rsp_valid <= 1'b1;
                    end
                end
                st_wait_drop: begin
                    if (!mem_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ereq_valid && ereq_ready) begin
            cur <= ereq;
        end
        if (state == st_wait_ack && mem_ack) begin
            rsp.write <= cur.write;
            rsp.idx   <= cur.idx;
            rsp.sew   <= cur.sew;
            rsp.lane  <= cur.addr[1:0];
            rsp.rdata <= mem_rdata;   // Read data valid with ack
        end
    end

endmodule

// File: hdl/lsu_elem_gen.sv
// ********************
// Element stage of the LSU
// Turns an issued index into address, lane-aligned store data and strobe
// One registered output slot, held while the memory stage is busy
// ********************
`timescale 1ns/1ps

module lsu_elem_gen #(
    parameter int vlen = lsu_pkg::vlen
) (
    input  logic                      clk,
    input  logic                      n_rst,
    input  lsu_pkg::lsu_cmd_t         cmd_q,
    input  logic                      issue_valid,
    input  logic [lsu_pkg::idx_w-1:0] issue_idx,
    output logic                      issue_ready,
    output logic                      ereq_valid,
    output lsu_pkg::elem_req_t        ereq,
    input  logic                      ereq_ready
);
    import lsu_pkg::*;

    logic [vlen-1:0] vs2_v;      // Offset vector at this unit's register width
    logic [vlen-1:0] vs3_v;      // Store data vector
    logic [xlen-1:0] next_addr;  // Running address in stride mode
    logic [xlen-1:0] elem_addr;
    logic [31:0]     elem_data;  // vs3 element, still in lane 0
    logic [1:0]      lane;
    logic            issue_fire;

    // Element i of a vector read at width s, zero-extended
    function automatic logic [31:0] pick(input logic [vlen-1:0] v,
                                         input logic [idx_w-1:0] i,
                                         input sew_e s);
        case (s)
            e8:      return 32'(v[i*8 +: 8]);
            e16:     return 32'(v[i*16 +: 16]);
            default: return v[i*32 +: 32];
        endcase
    endfunction

    assign vs2_v = vlen'(cmd_q.vs2);
    assign vs3_v = vlen'(cmd_q.vs3);

    always_comb begin
        if (cmd_q.mode == mode_index) begin
            elem_addr = cmd_q.base + pick(vs2_v, issue_idx, cmd_q.sew);
        end else if (issue_idx == '0) begin
            elem_addr = cmd_q.base;    // First element starts the running address
        end else begin
            elem_addr = next_addr;
        end
    end

    assign lane        = elem_addr[1:0];  // Aligned to the element size
    assign elem_data   = pick(vs3_v, issue_idx, cmd_q.sew);
    assign issue_ready = !ereq_valid || ereq_ready;  // Slot empty or draining
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ereq_valid <= 1'b0;
        end else if (issue_ready) begin
            ereq_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            ereq.write <= (cmd_q.op == op_store);
            ereq.addr  <= elem_addr;
            ereq.wdata <= elem_data << (8 * lane);           // Move into its byte lane
            ereq.strb  <= sew_strb(cmd_q.sew) << lane;
            ereq.idx   <= issue_idx;
            ereq.sew   <= cmd_q.sew;
            next_addr  <= elem_addr + cmd_q.stride;          // Negative stride wraps down
        end
    end

endmodule

// File: hdl/lsu_seq.sv
// ********************
// Command stage of the LSU
// Latches a command, checks it, issues element indices in order
// and raises cmd_ack once every element has completed
// ********************
`timescale 1ns/1ps

module lsu_seq #(
    parameter int vlen = lsu_pkg::vlen
) (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      cmd_req,
    input  lsu_pkg::lsu_cmd_t         cmd,
    output logic                      cmd_ack,
    output logic                      cmd_err,
    output lsu_pkg::lsu_cmd_t         cmd_q,
    output logic                      new_cmd,      // Pulse on command latch
    output logic                      issue_valid,
    output logic [lsu_pkg::idx_w-1:0] issue_idx,
    input  logic                      issue_ready,
    input  logic                      elem_done     // One pulse per finished element
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        s_idle,   // Waiting for cmd_req
        s_check,  // Legality check on the latched command
        s_run,    // Issuing and counting completions
        s_done    // cmd_ack high until cmd_req drops
    } seq_state_e;

    seq_state_e      state;
    logic [vl_w-1:0] issue_cnt;  // Indices handed to the element stage
    logic [vl_w-1:0] done_cnt;   // Elements written back
    int unsigned     max_vl;     // Register capacity at the command's width
    logic            legal;

    always_comb begin
        case (cmd_q.sew)
            e8:      max_vl = vlen / 8;
            e16:     max_vl = vlen / 16;
            e32:     max_vl = vlen / 32;
            default: max_vl = 0;
        endcase
    end

    assign legal       = (cmd_q.sew != e64) && (cmd_q.vl <= max_vl);
    assign new_cmd     = (state == s_idle) && cmd_req;
    assign issue_valid = (state == s_run) && (issue_cnt < cmd_q.vl);
    assign issue_idx   = issue_cnt[idx_w-1:0];

    // Command held for the whole operation
    always_ff @(posedge clk) begin
        if (new_cmd) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state     <= s_idle;
            cmd_ack   <= 1'b0;
            cmd_err   <= 1'b0;
            issue_cnt <= '0;
            done_cnt  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (cmd_req) begin
                        state     <= s_check;
                        cmd_err   <= 1'b0;   // Flag from the last command goes away
                        issue_cnt <= '0;
                        done_cnt  <= '0;
                    end
                end
                s_check: begin
                    // Illegal or empty commands finish without memory traffic
                    if (!legal || cmd_q.vl == '0) begin
                        state   <= s_done;
                        cmd_ack <= 1'b1;
                        cmd_err <= !legal;
                    end else begin
                        state <= s_run;
                    end
                end
                s_run: begin
                    if (issue_valid && issue_ready) begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                    if (elem_done) begin
                        done_cnt <= done_cnt + 1'b1;
                        if (done_cnt + 1'b1 == cmd_q.vl) begin  // Last element back
                            state   <= s_done;
                            cmd_ack <= 1'b1;
                        end
                    end
                end
                s_done: begin
                    if (!cmd_req) begin   // Four-phase return to zero
                        cmd_ack <= 1'b0;
                        state   <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: hdl/lsu_pkg.sv
// ********************
// Shared widths, codes and bundles for the vector load/store unit
// Imported by every RTL stage and by the testbench
// ********************

package lsu_pkg;

    localparam int xlen      = 32;                 // Address and scalar width
    localparam int vlen      = 128;                // Vector register width
    localparam int max_elems = vlen / 8;           // Most elements per register, at e8
    localparam int idx_w     = $clog2(max_elems);  // Element index width
    localparam int vl_w      = idx_w + 1;          // Holds 0 up to max_elems

    // Element width codes
    typedef enum logic [1:0] {
        e8  = 2'b00,
        e16 = 2'b01,
        e32 = 2'b10,
        e64 = 2'b11     // Reserved, rejected as illegal
    } sew_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } lsu_op_e;

    typedef enum logic {
        mode_stride = 1'b0,  // base + i * stride
        mode_index  = 1'b1   // base + vs2[i]
    } lsu_mode_e;

    typedef struct packed {
        lsu_op_e                op;
        lsu_mode_e              mode;
        sew_e                   sew;
        logic [vl_w-1:0]        vl;
        logic [xlen-1:0]        base;
        logic signed [xlen-1:0] stride;  // In bytes
        logic [vlen-1:0]        vs2;     // Offsets for indexed mode
        logic [vlen-1:0]        vs3;     // Store data
    } lsu_cmd_t;

    // One element access, element stage to memory stage
    typedef struct packed {
        logic             write;
        logic [xlen-1:0]  addr;
        logic [31:0]      wdata;  // Already shifted to its lane
        logic [3:0]       strb;
        logic [idx_w-1:0] idx;
        sew_e             sew;
    } elem_req_t;

    // One finished access, memory stage to writeback
    typedef struct packed {
        logic             write;
        logic [idx_w-1:0] idx;
        sew_e             sew;
        logic [1:0]       lane;   // Byte lane the element sits in
        logic [31:0]      rdata;
    } elem_rsp_t;

    typedef struct packed {
        logic            write;
        logic [xlen-1:0] addr;
        logic [31:0]     wdata;
        logic [3:0]      strb;
    } mem_req_t;

    // Byte strobe of one element sitting in lane 0
    function automatic logic [3:0] sew_strb(input sew_e s);
        case (s)
            e8:      return 4'b0001;
            e16:     return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

endpackage
